// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_openadc_lite
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: adc_cfg_if.sv
`timescale 1ns/10ps

interface adc_cfg_if;
   import adc_iface_pkg::*;

   logic      arm;
   logic      trig_en;
   logic      src_adc;
   sample_t   trig_level;
   reg_data_t gain;      // pwm increment
   led_sel_t  led_sel;

   // register file side
   modport regs (
      output arm, trig_en, src_adc, trig_level, gain, led_sel
   );

   // level trigger
   modport trig (
      input arm, trig_en, trig_level
   );

   // leds and pwm
   modport hk (
      input gain, led_sel
   );

endinterface

// File: adc_front_end.sv
`timescale 1ns/10ps
`include "adc_iface_defs.svh"

module adc_front_end (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  logic                   src_adc_i,
   input  adc_iface_pkg::sample_t adc_data_i,
   output adc_iface_pkg::sample_t sample_o
);
   import adc_iface_pkg::*;

   logic [`ADC_BITS-1:0] pattern_cnt;  // test pattern
   sample_t              stage1_q;

   always_ff @(posedge clk_usb) begin
      if (reset)
         pattern_cnt <= '0;
      else
         pattern_cnt <= pattern_cnt + 1'b1;
   end

   // select, then resample once more
   always_ff @(posedge clk_usb) begin
      stage1_q <= src_adc_i ? adc_data_i : pattern_cnt;
      sample_o <= stage1_q;
   end

endmodule

// File: adc_iface_defs.svh
`ifndef ADC_IFACE_DEFS_SVH
`define ADC_IFACE_DEFS_SVH

// widths
`define ADC_BITS        12
`define REG_ADDR_BITS   8
`define REG_DATA_BITS   8
`define HB_BITS         26

// register map
`define ADDR_CTRL       8'h01
`define ADDR_GAIN       8'h02
`define ADDR_LED_SEL    8'h03
`define ADDR_TRIG_LO    8'h04   // level[7:0]
`define ADDR_TRIG_HI    8'h05   // level[11:8] in data[3:0]
`define ADDR_STATUS     8'h06   // read only

// ctrl bits
`define CTRL_ARM        0
`define CTRL_TRIG_EN    1
`define CTRL_SRC_ADC    2       // 1 = adc pins, 0 = counter

// status bits
`define ST_ARMED        0
`define ST_TRIGGERED    1
`define ST_PLL          2

`endif

// File: adc_iface_pkg.sv
`include "adc_iface_defs.svh"

package adc_iface_pkg;

   // one adc sample
   typedef logic [`ADC_BITS-1:0] sample_t;

   // one register byte
   typedef logic [`REG_DATA_BITS-1:0] reg_data_t;

   // led source select
   typedef enum logic [1:0] {
      LED_STATE  = 2'd0,   // armed / triggered
      LED_HEART  = 2'd1,   // heartbeat
      LED_FLASH2 = 2'd2,
      LED_FLASH3 = 2'd3
   } led_sel_t;

endpackage

// File: adc_level_trigger.sv
`timescale 1ns/10ps

module adc_level_trigger (
   input  logic                   clk_usb,
   input  logic                   reset,
   adc_cfg_if.trig                cfg,
   input  adc_iface_pkg::sample_t sample_i,
   output logic                   trigger_adc_o,
   output logic                   armed_o,
   output logic                   triggered_o
);
   import adc_iface_pkg::*;

   logic armed_q;
   logic triggered_q;
   logic level_hit;
   logic arm_rise;

   // level msb picks the direction
   assign level_hit = cfg.trig_level[$bits(sample_t)-1] ? (sample_i > cfg.trig_level)
                                                        : (sample_i < cfg.trig_level);
   assign arm_rise  = cfg.arm & ~armed_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed_q       <= 1'b0;
         triggered_q   <= 1'b0;
         trigger_adc_o <= 1'b0;
      end
      else begin
         armed_q <= cfg.arm;

         // pulse may not repeat before triggered catches up
         if (~triggered_q && ~trigger_adc_o && cfg.trig_en && armed_q)
            trigger_adc_o <= level_hit;
         else
            trigger_adc_o <= 1'b0;

         if (trigger_adc_o)
            triggered_q <= 1'b1;
         else if (arm_rise)
            triggered_q <= 1'b0;  // new arm, new pulse
      end
   end

   assign armed_o     = armed_q;
   assign triggered_o = triggered_q;

endmodule

// File: adc_regs.sv
`timescale 1ns/10ps
`include "adc_iface_defs.svh"

module adc_regs (
   input  logic                      clk_usb,
   input  logic                      reset,
   input  logic                      reg_write_i,
   input  logic                      reg_read_i,
   input  logic [`REG_ADDR_BITS-1:0] reg_addr_i,
   input  logic [`REG_DATA_BITS-1:0] reg_wdata_i,
   output adc_iface_pkg::reg_data_t  reg_data_o,
   input  logic                      pll_status_i,
   input  logic                      armed_i,
   input  logic                      triggered_i,
   adc_cfg_if.regs                   cfg,
   output logic                      src_adc_o
);
   import adc_iface_pkg::*;

   logic [2:0] ctrl_q;           // src_adc, trig_en, arm
   reg_data_t  gain_q;
   led_sel_t   led_sel_q;
   sample_t    trig_level_q;
   reg_data_t  status_w;
   reg_data_t  rdata;

   always_comb begin
      status_w = '0;
      status_w[`ST_ARMED]     = armed_i;
      status_w[`ST_TRIGGERED] = triggered_i;
      status_w[`ST_PLL]       = pll_status_i;
   end

   // read mux, unmapped addresses give zero
   always_comb begin
      case (reg_addr_i)
         `ADDR_CTRL:    rdata = {{(`REG_DATA_BITS-3){1'b0}}, ctrl_q};
         `ADDR_GAIN:    rdata = gain_q;
         `ADDR_LED_SEL: rdata = {{(`REG_DATA_BITS-2){1'b0}}, led_sel_q};
         `ADDR_TRIG_LO: rdata = trig_level_q[7:0];
         `ADDR_TRIG_HI: rdata = {{(2*`REG_DATA_BITS-`ADC_BITS){1'b0}},
                                trig_level_q[`ADC_BITS-1:8]};
         `ADDR_STATUS:  rdata = status_w;
         default:       rdata = '0;
      endcase
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ctrl_q       <= '0;
         gain_q       <= '0;
         led_sel_q    <= LED_STATE;
         trig_level_q <= '0;
         reg_data_o   <= '0;
      end
      else begin
         if (reg_write_i) begin
            case (reg_addr_i)
               `ADDR_CTRL:    ctrl_q <= reg_wdata_i[2:0];
               `ADDR_GAIN:    gain_q <= reg_wdata_i;
               `ADDR_LED_SEL: led_sel_q <= led_sel_t'(reg_wdata_i[1:0]);
               `ADDR_TRIG_LO: trig_level_q[7:0] <= reg_wdata_i;
               `ADDR_TRIG_HI: begin
                  trig_level_q[`ADC_BITS-1:8] <= reg_wdata_i[`ADC_BITS-9:0];
               end
               default: ;    // status and unmapped are read only
            endcase
         end
         if (reg_read_i)
            reg_data_o <= rdata;  // held until next read
      end
   end

   assign cfg.arm        = ctrl_q[`CTRL_ARM];
   assign cfg.trig_en    = ctrl_q[`CTRL_TRIG_EN];
   assign cfg.src_adc    = ctrl_q[`CTRL_SRC_ADC];
   assign cfg.trig_level = trig_level_q;
   assign cfg.gain       = gain_q;
   assign cfg.led_sel    = led_sel_q;

   assign src_adc_o = cfg.src_adc;

endmodule

// File: board_housekeeping.sv
`timescale 1ns/10ps
`include "adc_iface_defs.svh"

module board_housekeeping (
   input  logic   clk_usb,
   input  logic   reset,
   input  logic   armed_i,
   input  logic   triggered_i,
   adc_cfg_if.hk  cfg,
   output logic   freq_measure_o,
   output logic   led_armed_o,
   output logic   led_capture_o,
   output logic   amp_gain_o,
   output logic   flash_pattern_o
);
   import adc_iface_pkg::*;

   logic [`HB_BITS-1:0]     timer_hb;
   logic                    timer22_q;
   logic [`REG_DATA_BITS:0] pwm_acc;    // msb is the carry

   // heartbeat timer and measurement strobe
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_hb       <= '0;
         timer22_q      <= 1'b0;
         freq_measure_o <= 1'b0;
      end
      else begin
         timer_hb       <= timer_hb + 1'b1;
         timer22_q      <= timer_hb[22];
         freq_measure_o <= timer_hb[22] & ~timer22_q;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset)
         flash_pattern_o <= 1'b0;
      else if (timer_hb[25])
         flash_pattern_o <= ~timer_hb[23];  // blinks in upper half only
   end

   // pwm for the amplifier gain
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= pwm_acc[`REG_DATA_BITS-1:0] + cfg.gain;
   end

   assign amp_gain_o = pwm_acc[`REG_DATA_BITS];

   always_comb begin
      led_armed_o   = flash_pattern_o;
      led_capture_o = flash_pattern_o;
      case (cfg.led_sel)
         LED_STATE: begin
            led_armed_o   = armed_i;
            led_capture_o = triggered_i;
         end
         LED_HEART: begin
            led_armed_o   = timer_hb[24];
            led_capture_o = timer_hb[24];
         end
         default: ;   // flash codes
      endcase
   end

endmodule

// File: openadc_lite_top.sv
`timescale 1ns/10ps

module openadc_lite_top (
   input  logic        clk_usb,
   input  logic        reset,
   input  logic        reg_write_i,
   input  logic        reg_read_i,
   input  logic [7:0]  reg_addr_i,
   input  logic [7:0]  reg_wdata_i,
   output logic [7:0]  reg_data_o,
   input  logic        pll_status_i,
   input  logic [11:0] adc_data_i,
   output logic        trigger_adc_o,
   output logic        amp_gain_o,
   output logic        freq_measure_o,
   output logic        led_armed_o,
   output logic        led_capture_o,
   output logic        flash_pattern_o
);
   import adc_iface_pkg::*;

   sample_t sample;
   logic    src_adc;
   logic    armed;
   logic    triggered;

   adc_cfg_if cfg_if ();

   adc_regs u_regs (
      .clk_usb      (clk_usb),
      .reset        (reset),
      .reg_write_i  (reg_write_i),
      .reg_read_i   (reg_read_i),
      .reg_addr_i   (reg_addr_i),
      .reg_wdata_i  (reg_wdata_i),
      .reg_data_o   (reg_data_o),
      .pll_status_i (pll_status_i),
      .armed_i      (armed),
      .triggered_i  (triggered),
      .cfg          (cfg_if.regs),
      .src_adc_o    (src_adc)
   );

   adc_front_end u_front_end (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .src_adc_i  (src_adc),
      .adc_data_i (adc_data_i),
      .sample_o   (sample)
   );

   adc_level_trigger u_trigger (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .cfg           (cfg_if.trig),
      .sample_i      (sample),
      .trigger_adc_o (trigger_adc_o),
      .armed_o       (armed),
      .triggered_o   (triggered)
   );

   board_housekeeping u_housekeeping (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .armed_i         (armed),
      .triggered_i     (triggered),
      .cfg             (cfg_if.hk),
      .freq_measure_o  (freq_measure_o),
      .led_armed_o     (led_armed_o),
      .led_capture_o   (led_capture_o),
      .amp_gain_o      (amp_gain_o),
      .flash_pattern_o (flash_pattern_o)
   );

endmodule

// File: openadc_testdata.txt
# op f1 f2, hex: W addr data | R addr expected | A adc_value 0 | T pulses 0 | G gain highs
# counter source test first, the pattern counter starts at zero when reset ends
W 04 10
W 01 03
T 01 00
R 06 07
W 01 00
R 06 06
R 01 00
R 07 00
W 02 5a
R 02 5a
W 03 01
R 03 01
W 03 00
W 05 fa
R 05 0a
W 04 34
R 04 34
# level a34 fires above, adc source
A b00 00
W 01 04
W 01 07
T 01 00
R 06 07
T 00 00
W 01 06
W 01 07
T 01 00
R 06 07
A a00 00
W 01 06
W 01 07
T 00 00
R 06 05
# level 123 fires below
W 01 06
W 05 01
W 04 23
A 100 00
W 01 07
T 01 00
R 06 07
G 40 40
G ff ff
G 01 01
W 03 02
R 03 02

// File: sources.f
+incdir+.
adc_iface_pkg.sv
adc_cfg_if.sv
adc_regs.sv
adc_front_end.sv
adc_level_trigger.sv
board_housekeeping.sv
openadc_lite_top.sv
tb_openadc_lite.sv

// File: tb_openadc_lite.sv
`timescale 1ns/10ps
`include "adc_iface_defs.svh"

module tb_openadc_lite;
   import adc_iface_pkg::*;

   localparam string DATA_FILE  = "openadc_testdata.txt";
   localparam int    MAX_LINES  = 1000;
   localparam int    TRIG_WIN   = 40;
   localparam int    PWM_WIN    = 256;

   logic        clk_usb;
   logic        reset;
   logic        reg_write_i;
   logic        reg_read_i;
   logic [7:0]  reg_addr_i;
   logic [7:0]  reg_wdata_i;
   logic [7:0]  reg_data_o;
   logic        pll_status_i;
   logic [11:0] adc_data_i;
   logic        trigger_adc_o;
   logic        amp_gain_o;
   logic        freq_measure_o;
   logic        led_armed_o;
   logic        led_capture_o;
   logic        flash_pattern_o;

   int          errors;
   int          checks;
   logic [1:0]  led_sel_sh;     // last value written to the led select register

   openadc_lite_top i_dut (.*);

   initial begin
      clk_usb = 1'b0;
      forever #50 clk_usb = ~clk_usb;
   end

   // inputs change 10 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk_usb);
      #10;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      reg_addr_i  = addr;
      reg_wdata_i = data;
      reg_write_i = 1'b1;
      next_cycle();
      reg_write_i = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
      reg_addr_i = addr;
      reg_read_i = 1'b1;
      next_cycle();
      reg_read_i = 1'b0;
      data       = reg_data_o;
   endtask

   task automatic report_mismatch(input string name, input int got, input int exp);
      errors++;
      $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
   endtask

   // status is captured from the same armed/triggered state the leds show now
   task automatic check_leds();
      logic       led_a;
      logic       led_c;
      logic [7:0] st;
      if (led_sel_sh == LED_FLASH2 || led_sel_sh == LED_FLASH3) begin
         checks++;
         if (led_armed_o !== flash_pattern_o || led_capture_o !== flash_pattern_o)
            report_mismatch("led_armed_o,led_capture_o", {led_armed_o, led_capture_o},
                            {2{flash_pattern_o}});
         return;
      end
      if (led_sel_sh != LED_STATE)
         return;
      led_a = led_armed_o;
      led_c = led_capture_o;
      read_reg(`ADDR_STATUS, st);
      checks++;
      if (led_a !== st[`ST_ARMED] || led_c !== st[`ST_TRIGGERED])
         report_mismatch("led_armed_o,led_capture_o", {led_a, led_c},
                         {st[`ST_ARMED], st[`ST_TRIGGERED]});
   endtask

   // heartbeat bit 22 cannot rise within a run this short
   always @(negedge clk_usb) begin
      if (reset === 1'b0 && freq_measure_o !== 1'b0)
         report_mismatch("freq_measure_o", freq_measure_o, 0);
   end

   initial begin
      int          fd;
      int          nf;
      int          line_no;
      int          count;
      string       line;
      logic [7:0]  op;
      logic [15:0] f1;
      logic [15:0] f2;
      logic [7:0]  rd;
      errors       = 0;
      checks       = 0;
      line_no      = 0;
      led_sel_sh   = LED_STATE;
      reset        = 1'b1;
      reg_write_i  = 1'b0;
      reg_read_i   = 1'b0;
      reg_addr_i   = '0;
      reg_wdata_i  = '0;
      pll_status_i = 1'b1;
      adc_data_i   = '0;
      repeat (16) @(posedge clk_usb);
      #10 reset = 1'b0;

      fd = $fopen(DATA_FILE, "r");
      if (fd == 0) begin
         $display("could not open the data file %s", DATA_FILE);
         errors++;
      end
      else begin
         while (!$feof(fd) && line_no < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() < 3 || line[0] == "#")
               continue;
            nf = $sscanf(line, "%c %h %h", op, f1, f2);
            if (nf != 3) begin
               $display("data line %0d could not be parsed", line_no);
               errors++;
               continue;
            end
            case (op)
               "W": begin
                  write_reg(f1[7:0], f2[7:0]);
                  if (f1[7:0] == `ADDR_LED_SEL)
                     led_sel_sh = f2[1:0];
               end
               "R": begin
                  next_cycle();   // armed trails the arm bit by a cycle
                  read_reg(f1[7:0], rd);
                  checks++;
                  if (rd !== f2[7:0])
                     report_mismatch("reg_data_o", rd, f2[7:0]);
                  check_leds();
               end
               "A": begin
                  adc_data_i = f1[11:0];
                  check_leds();
               end
               "T": begin
                  count = 0;
                  repeat (TRIG_WIN) begin
                     next_cycle();
                     if (trigger_adc_o)
                        count++;
                  end
                  checks++;
                  if (count != f1)
                     report_mismatch("trigger_adc_o pulses", count, f1);
                  check_leds();
               end
               "G": begin
                  write_reg(`ADDR_GAIN, f1[7:0]);
                  next_cycle();   // old gain out of the accumulator
                  count = 0;
                  repeat (PWM_WIN) begin
                     next_cycle();
                     if (amp_gain_o)
                        count++;
                  end
                  checks++;
                  if (count != f2)
                     report_mismatch("amp_gain_o high cycles", count, f2);
                  check_leds();
               end
               default: begin
                  $display("unknown opcode on data line %0d", line_no);
                  errors++;
               end
            endcase
         end
         $fclose(fd);
      end

      if (checks == 0) begin
         $display("no checks were run");
         errors++;
      end
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule
